// ==== rtl/regmap_pkg.sv ====
package regmap_pkg;

    // Bus geometry
    localparam int BUS_ADDR_WIDTH = 16;
    localparam int BUS_DATA_WIDTH = 32;
    localparam int OFFSET_WIDTH   = 12;    // Offset inside a region
    localparam int REGION_WIDTH   = BUS_ADDR_WIDTH - OFFSET_WIDTH;

    typedef logic [BUS_ADDR_WIDTH-1:0] bus_addr_t;
    typedef logic [BUS_DATA_WIDTH-1:0] bus_data_t;
    typedef logic [OFFSET_WIDTH-1:0]   offset_t;
    typedef logic [REGION_WIDTH-1:0]   region_t;

    // Single registers, all in region 0
    localparam bus_addr_t REG_CTRL   = 16'h0010;
    localparam bus_addr_t REG_STATUS = 16'h0028;
    localparam bus_addr_t REG_MODE   = 16'h0030;

    // Control register fields
    localparam int CTRL_TX_EN_BIT  = 16;
    localparam int CTRL_CAP_EN_BIT = 17;

    // Table regions in address bits 15:12
    localparam region_t REGION_ADC      = 4'd1;    // Read only
    localparam region_t REGION_BASELINE = 4'd2;
    localparam region_t REGION_NOISE    = 4'd3;

    // Channels sit 8 bytes apart inside a region
    localparam int CHAN_STRIDE_SHIFT = 3;
    localparam int CHAN_SEL_WIDTH    = OFFSET_WIDTH - CHAN_STRIDE_SHIFT;

    typedef logic [CHAN_SEL_WIDTH-1:0] chan_sel_t;

    // Returned for holes in the map
    localparam bus_data_t UNMAPPED_DATA = 32'hDEAD_BEEF;

    // Control register reset values
    localparam logic CTRL_TX_EN_RST  = 1'b1;
    localparam logic CTRL_CAP_EN_RST = 1'b0;

endpackage

// ==== rtl/ctrl_pkg.sv ====
package ctrl_pkg;

    // Front end geometry
    localparam int NUM_CHANNELS   = 4;
    localparam int ADC_WIDTH      = 12;
    localparam int SAMPLE_WIDTH   = 16;
    localparam int CHAN_IDX_WIDTH = $clog2(NUM_CHANNELS);
    localparam int MODE_WIDTH     = 5;
    localparam int STATUS_WIDTH   = 5;

    typedef logic [ADC_WIDTH-1:0]              adc_word_t;
    typedef logic [SAMPLE_WIDTH-1:0]           sample_t;
    typedef logic [CHAN_IDX_WIDTH-1:0]         chan_idx_t;
    typedef logic [NUM_CHANNELS*ADC_WIDTH-1:0] adc_bus_t;    // Channel 0 in the low bits
    typedef logic [MODE_WIDTH-1:0]             mode_t;
    typedef logic [STATUS_WIDTH-1:0]           status_t;

    // Working modes
    localparam mode_t MODE_IDLE = 5'd0;
    localparam mode_t MODE_CAL  = 5'd1;
    localparam mode_t MODE_ACQ  = 5'd2;
    localparam mode_t MODE_RST  = MODE_CAL;    // Mode out of reset

    // Status codes
    localparam status_t STAT_WAIT            = 5'd0;
    localparam status_t STAT_INIT_FINISH     = 5'd1;
    localparam status_t STAT_MEASURE_START   = 5'd2;
    localparam status_t STAT_MEASURE_FINISH  = 5'd3;
    localparam status_t STAT_CLUSTER_FINDING = 5'd4;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CAPTURE,
        ST_TRANSMIT,
        ST_MESSAGE
    } acq_state_e;

    // Configuration held by the register bank
    typedef struct packed {
        mode_t   mode;
        status_t status;    // As written, not as reported
        logic    tx_en;
        logic    cap_en;
    } cfg_t;

    // Registered outputs of the system FSM
    typedef struct packed {
        logic tx_enable;
        logic msg_send;
        logic capture;
    } ctrl_t;

endpackage

// ==== rtl/reg_bank.sv ====
module reg_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  regmap_pkg::bus_addr_t bus_addr_i,
    input  regmap_pkg::bus_data_t bus_wdata_i,
    input  logic                  bus_we_i,
    output regmap_pkg::bus_data_t bus_rdata_o,
    input  ctrl_pkg::adc_bus_t    adc_data_i,
    input  logic                  adc_valid_i,
    input  ctrl_pkg::ctrl_t       ctrl_i,
    output ctrl_pkg::cfg_t        cfg_o
);

    ctrl_pkg::cfg_t      cfg_q;
    ctrl_pkg::sample_t   baseline_mem [ctrl_pkg::NUM_CHANNELS];
    ctrl_pkg::sample_t   noise_mem    [ctrl_pkg::NUM_CHANNELS];
    ctrl_pkg::adc_word_t adc_mem      [ctrl_pkg::NUM_CHANNELS];

    regmap_pkg::region_t   region;
    regmap_pkg::offset_t   offset;
    regmap_pkg::chan_sel_t chan_sel;
    ctrl_pkg::chan_idx_t   chan_idx;
    logic                  chan_ok;
    logic                  wr_baseline;
    logic                  wr_noise;
    ctrl_pkg::status_t     status_rpt;

    // Address split shared by the write and read paths
    assign region   = bus_addr_i[regmap_pkg::BUS_ADDR_WIDTH-1:regmap_pkg::OFFSET_WIDTH];
    assign offset   = bus_addr_i[regmap_pkg::OFFSET_WIDTH-1:0];
    assign chan_sel = regmap_pkg::chan_sel_t'(offset >> regmap_pkg::CHAN_STRIDE_SHIFT);
    assign chan_ok  = (chan_sel < ctrl_pkg::NUM_CHANNELS);
    assign chan_idx = ctrl_pkg::chan_idx_t'(chan_sel);

    assign wr_baseline = bus_we_i && chan_ok && (region == regmap_pkg::REGION_BASELINE);
    assign wr_noise    = bus_we_i && chan_ok && (region == regmap_pkg::REGION_NOISE);

    // Control, status and mode registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q.mode   <= ctrl_pkg::MODE_RST;
            cfg_q.status <= ctrl_pkg::STAT_WAIT;
            cfg_q.tx_en  <= regmap_pkg::CTRL_TX_EN_RST;
            cfg_q.cap_en <= regmap_pkg::CTRL_CAP_EN_RST;
        end else if (bus_we_i) begin
            case (bus_addr_i)
                regmap_pkg::REG_CTRL: begin
                    cfg_q.tx_en  <= bus_wdata_i[regmap_pkg::CTRL_TX_EN_BIT];
                    cfg_q.cap_en <= bus_wdata_i[regmap_pkg::CTRL_CAP_EN_BIT];
                end
                regmap_pkg::REG_STATUS: begin
                    cfg_q.status <= bus_wdata_i[ctrl_pkg::STATUS_WIDTH-1:0];
                end
                regmap_pkg::REG_MODE: begin
                    cfg_q.mode <= bus_wdata_i[ctrl_pkg::MODE_WIDTH-1:0];
                end
                default: ;
            endcase
        end
    end

    // Baseline and noise tables take the low half of the data word
    always_ff @(posedge clk) begin
        if (wr_baseline) begin
            baseline_mem[chan_idx] <= bus_wdata_i[ctrl_pkg::SAMPLE_WIDTH-1:0];
        end
        if (wr_noise) begin
            noise_mem[chan_idx] <= bus_wdata_i[ctrl_pkg::SAMPLE_WIDTH-1:0];
        end
    end

    // All channels latch together while the FSM is capturing
    always_ff @(posedge clk) begin
        if (ctrl_i.capture && adc_valid_i) begin
            for (int i = 0; i < ctrl_pkg::NUM_CHANNELS; i++) begin
                adc_mem[i] <= adc_data_i[i*ctrl_pkg::ADC_WIDTH +: ctrl_pkg::ADC_WIDTH];
            end
        end
    end

    // Status as seen by the processor depends on the mode
    always_comb begin
        case (cfg_q.mode)
            ctrl_pkg::MODE_CAL: begin
                if (cfg_q.status != ctrl_pkg::STAT_MEASURE_FINISH) begin
                    status_rpt = ctrl_pkg::STAT_MEASURE_START;
                end else begin
                    status_rpt = cfg_q.status;
                end
            end
            ctrl_pkg::MODE_IDLE: status_rpt = ctrl_pkg::STAT_WAIT;
            ctrl_pkg::MODE_ACQ:  status_rpt = ctrl_pkg::STAT_CLUSTER_FINDING;
            default:             status_rpt = cfg_q.status;
        endcase
    end

    // Read mux, no side effects
    always_comb begin
        bus_rdata_o = regmap_pkg::UNMAPPED_DATA;
        case (bus_addr_i)
            regmap_pkg::REG_CTRL: begin
                bus_rdata_o = '0;
                bus_rdata_o[regmap_pkg::CTRL_TX_EN_BIT]  = cfg_q.tx_en;
                bus_rdata_o[regmap_pkg::CTRL_CAP_EN_BIT] = cfg_q.cap_en;
            end
            regmap_pkg::REG_STATUS: begin
                bus_rdata_o = regmap_pkg::bus_data_t'(status_rpt);
            end
            default: begin
                if (chan_ok) begin
                    if (region == regmap_pkg::REGION_ADC) begin
                        bus_rdata_o = regmap_pkg::bus_data_t'(adc_mem[chan_idx]);
                    end else if (region == regmap_pkg::REGION_BASELINE) begin
                        bus_rdata_o = regmap_pkg::bus_data_t'(baseline_mem[chan_idx]);
                    end else if (region == regmap_pkg::REGION_NOISE) begin
                        bus_rdata_o = regmap_pkg::bus_data_t'(noise_mem[chan_idx]);
                    end
                end
            end
        endcase
    end

    assign cfg_o = cfg_q;

endmodule

// ==== rtl/acq_fsm.sv ====
module acq_fsm (
    input  logic            clk,
    input  logic            rst_n,
    input  ctrl_pkg::cfg_t  cfg_i,
    input  logic            adc_valid_i,
    input  logic            tx_busy_i,
    input  logic            tx_done_i,
    output ctrl_pkg::ctrl_t ctrl_o
);

    ctrl_pkg::acq_state_e state_q;
    ctrl_pkg::mode_t      mode_q;    // Mode one cycle ago
    ctrl_pkg::ctrl_t      ctrl_q;
    logic                 run_q;

    logic mode_changed;
    logic start_capture;
    logic cal_go;
    logic acq_go;
    logic tx_finish;

    assign mode_changed = (cfg_i.mode != mode_q);

    assign start_capture = cfg_i.cap_en && run_q && (cfg_i.mode != ctrl_pkg::MODE_IDLE);

    // Calibration waits for software to finish the measurement
    assign cal_go = (cfg_i.mode == ctrl_pkg::MODE_CAL) &&
                    (cfg_i.status == ctrl_pkg::STAT_MEASURE_FINISH);
    assign acq_go = (cfg_i.mode == ctrl_pkg::MODE_ACQ) && adc_valid_i;

    assign tx_finish = tx_done_i || !tx_busy_i;

    // Delayed mode copy and run latch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q <= ctrl_pkg::MODE_RST;    // Reset alone sends no message
            run_q  <= 1'b0;
        end else begin
            mode_q <= cfg_i.mode;
            if (cfg_i.status == ctrl_pkg::STAT_INIT_FINISH) begin
                run_q <= 1'b1;    // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ctrl_pkg::ST_IDLE;
            ctrl_q  <= '0;
        end else if (mode_changed) begin
            // Any mode write announces itself first
            state_q          <= ctrl_pkg::ST_MESSAGE;
            ctrl_q.tx_enable <= 1'b1;
            ctrl_q.msg_send  <= 1'b1;
            ctrl_q.capture   <= 1'b0;
        end else begin
            case (state_q)
                ctrl_pkg::ST_IDLE: begin
                    ctrl_q.tx_enable <= 1'b0;
                    ctrl_q.msg_send  <= 1'b0;
                    ctrl_q.capture   <= start_capture;
                    if (start_capture) begin
                        state_q <= ctrl_pkg::ST_CAPTURE;
                    end
                end
                ctrl_pkg::ST_CAPTURE: begin
                    if (cfg_i.tx_en && (cal_go || acq_go)) begin
                        ctrl_q.tx_enable <= 1'b1;
                        ctrl_q.capture   <= 1'b0;
                        state_q          <= ctrl_pkg::ST_TRANSMIT;
                    end
                end
                ctrl_pkg::ST_TRANSMIT: begin
                    // Held here only by a busy transmitter
                    if (tx_finish) begin
                        state_q <= ctrl_pkg::ST_IDLE;
                    end
                end
                ctrl_pkg::ST_MESSAGE: begin
                    ctrl_q.tx_enable <= 1'b1;
                    ctrl_q.msg_send  <= 1'b1;
                    if (tx_done_i) begin
                        state_q <= ctrl_pkg::ST_IDLE;    // Outputs drop in idle
                    end
                end
                default: begin
                    state_q <= ctrl_pkg::ST_IDLE;
                    ctrl_q  <= '0;
                end
            endcase
        end
    end

    assign ctrl_o = ctrl_q;

endmodule

// ==== rtl/tx_release.sv ====
module tx_release (
    input  logic           clk,
    input  logic           rst_n,
    input  ctrl_pkg::cfg_t cfg_i,
    input  logic           tx_enable_i,
    input  logic           tx_done_i,
    output logic           data_accept_o
);

    logic done_q;
    logic done_rise_q;
    logic pending_q;
    logic first_sent_q;
    logic force_release;

    // Calibration result is streamed without waiting on the transmitter
    assign force_release = (cfg_i.status == ctrl_pkg::STAT_MEASURE_FINISH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q        <= 1'b0;
            done_rise_q   <= 1'b0;
            pending_q     <= 1'b0;
            first_sent_q  <= 1'b0;
            data_accept_o <= 1'b0;
        end else begin
            done_q      <= tx_done_i;
            done_rise_q <= tx_done_i && !done_q;

            if (done_rise_q) begin
                pending_q <= 1'b1;
            end

            if ((tx_enable_i && !first_sent_q) || force_release) begin
                data_accept_o <= 1'b1;
                first_sent_q  <= 1'b1;
                pending_q     <= 1'b0;
            end else if (pending_q) begin
                data_accept_o <= 1'b1;    // One cycle per finished packet
                pending_q     <= 1'b0;
            end else begin
                data_accept_o <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/acq_ctrl_top.sv ====
module acq_ctrl_top (
    input  logic                  clk,
    input  logic                  rst_n,

    // Processor register bus
    input  regmap_pkg::bus_addr_t bus_addr_i,
    input  regmap_pkg::bus_data_t bus_wdata_i,
    input  logic                  bus_we_i,
    output regmap_pkg::bus_data_t bus_rdata_o,

    // ADC front end
    input  ctrl_pkg::adc_bus_t    adc_data_i,
    input  logic                  adc_valid_i,

    // Transmitter strobes
    input  logic                  tx_busy_i,
    input  logic                  tx_done_i,
    output logic                  tx_enable_o,
    output logic                  msg_send_o,
    output logic                  data_accept_o
);

    ctrl_pkg::cfg_t  cfg;
    ctrl_pkg::ctrl_t ctrl;

    reg_bank u_reg_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_we_i    (bus_we_i),
        .bus_rdata_o (bus_rdata_o),
        .adc_data_i  (adc_data_i),
        .adc_valid_i (adc_valid_i),
        .ctrl_i      (ctrl),
        .cfg_o       (cfg)
    );

    acq_fsm u_acq_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_i       (cfg),
        .adc_valid_i (adc_valid_i),
        .tx_busy_i   (tx_busy_i),
        .tx_done_i   (tx_done_i),
        .ctrl_o      (ctrl)
    );

    tx_release u_tx_release (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_i         (cfg),
        .tx_enable_i   (ctrl.tx_enable),
        .tx_done_i     (tx_done_i),
        .data_accept_o (data_accept_o)
    );

    assign tx_enable_o = ctrl.tx_enable;
    assign msg_send_o  = ctrl.msg_send;

endmodule

// ==== dv/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Software view of the programmed registers and tables
ctrl_pkg::mode_t   model_mode;
ctrl_pkg::status_t model_status;
logic              model_tx_en;
logic              model_cap_en;
ctrl_pkg::sample_t model_baseline [ctrl_pkg::NUM_CHANNELS];
ctrl_pkg::sample_t model_noise    [ctrl_pkg::NUM_CHANNELS];
ctrl_pkg::sample_t model_adc      [ctrl_pkg::NUM_CHANNELS];    // Zero-extended samples

function automatic void model_reset();
    model_mode   = ctrl_pkg::MODE_RST;
    model_status = ctrl_pkg::STAT_WAIT;
    model_tx_en  = regmap_pkg::CTRL_TX_EN_RST;
    model_cap_en = regmap_pkg::CTRL_CAP_EN_RST;
endfunction

// Channel index from the low 12 address bits
function automatic int chan_of(input regmap_pkg::bus_addr_t addr);
    return int'(addr[11:0]) >> regmap_pkg::CHAN_STRIDE_SHIFT;
endfunction

function automatic void model_write(input regmap_pkg::bus_addr_t addr,
                                    input regmap_pkg::bus_data_t data);
    if (addr == regmap_pkg::REG_CTRL) begin
        model_tx_en  = data[regmap_pkg::CTRL_TX_EN_BIT];
        model_cap_en = data[regmap_pkg::CTRL_CAP_EN_BIT];
    end else if (addr == regmap_pkg::REG_STATUS) begin
        model_status = data[4:0];
    end else if (addr == regmap_pkg::REG_MODE) begin
        model_mode = data[4:0];
    end else if (chan_of(addr) < ctrl_pkg::NUM_CHANNELS) begin
        if (addr[15:12] == regmap_pkg::REGION_BASELINE) begin
            model_baseline[chan_of(addr)] = data[15:0];
        end else if (addr[15:12] == regmap_pkg::REGION_NOISE) begin
            model_noise[chan_of(addr)] = data[15:0];
        end
    end
endfunction

// Reported status for a mode and a written status
function automatic ctrl_pkg::status_t exp_status(input ctrl_pkg::mode_t mode,
                                                 input ctrl_pkg::status_t status);
    if (mode == ctrl_pkg::MODE_CAL) begin
        if (status == ctrl_pkg::STAT_MEASURE_FINISH) begin
            return status;
        end
        return ctrl_pkg::STAT_MEASURE_START;
    end
    if (mode == ctrl_pkg::MODE_IDLE) begin
        return ctrl_pkg::STAT_WAIT;
    end
    if (mode == ctrl_pkg::MODE_ACQ) begin
        return ctrl_pkg::STAT_CLUSTER_FINDING;
    end
    return status;
endfunction

function automatic regmap_pkg::bus_data_t exp_read(input regmap_pkg::bus_addr_t addr);
    if (addr == regmap_pkg::REG_CTRL) begin
        return {14'd0, model_cap_en, model_tx_en, 16'd0};
    end
    if (addr == regmap_pkg::REG_STATUS) begin
        return {27'd0, exp_status(model_mode, model_status)};
    end
    if (chan_of(addr) >= ctrl_pkg::NUM_CHANNELS) begin
        return regmap_pkg::UNMAPPED_DATA;
    end
    if (addr[15:12] == regmap_pkg::REGION_ADC) begin
        return {16'd0, model_adc[chan_of(addr)]};
    end
    if (addr[15:12] == regmap_pkg::REGION_BASELINE) begin
        return {16'd0, model_baseline[chan_of(addr)]};
    end
    if (addr[15:12] == regmap_pkg::REGION_NOISE) begin
        return {16'd0, model_noise[chan_of(addr)]};
    end
    return regmap_pkg::UNMAPPED_DATA;    // Region 0 holes and unused regions
endfunction

`endif

// ==== dv/tb_acq_ctrl.sv ====
module tb_acq_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_TESTS       = 5;
    localparam int WATCHDOG_CYCLES = 600 + 50 * NUM_TESTS;

    logic                  clk;
    logic                  rst_n;
    regmap_pkg::bus_addr_t bus_addr;
    regmap_pkg::bus_data_t bus_wdata;
    logic                  bus_we;
    regmap_pkg::bus_data_t bus_rdata;
    ctrl_pkg::adc_bus_t    adc_data;
    logic                  adc_valid;
    logic                  tx_busy;
    logic                  tx_done;
    logic                  tx_enable;
    logic                  msg_send;
    logic                  data_accept;

    integer                seed;
    regmap_pkg::bus_data_t exp_q [$];    // Expected read data, oldest first
    string                 what_q [$];

    `include "tb_ref_model.svh"

    acq_ctrl_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus_addr_i    (bus_addr),
        .bus_wdata_i   (bus_wdata),
        .bus_we_i      (bus_we),
        .bus_rdata_o   (bus_rdata),
        .adc_data_i    (adc_data),
        .adc_valid_i   (adc_valid),
        .tx_busy_i     (tx_busy),
        .tx_done_i     (tx_done),
        .tx_enable_o   (tx_enable),
        .msg_send_o    (msg_send),
        .data_accept_o (data_accept)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check(input regmap_pkg::bus_data_t actual,
                         input regmap_pkg::bus_data_t expected, input string what);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch at %0t: %s, got %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    // Order is tx_enable, msg_send, data_accept
    task automatic check_outputs(input logic [2:0] expected, input string what);
        check({29'd0, tx_enable, msg_send, data_accept}, {29'd0, expected}, what);
    endtask

    function automatic regmap_pkg::bus_addr_t table_addr(input regmap_pkg::region_t region,
                                                         input int chan);
        return {region, 12'(chan << regmap_pkg::CHAN_STRIDE_SHIFT)};
    endfunction

    task automatic write_reg(input regmap_pkg::bus_addr_t addr,
                             input regmap_pkg::bus_data_t data);
        @(negedge clk);
        bus_addr  = addr;
        bus_wdata = data;
        bus_we    = 1'b1;
        model_write(addr, data);
        @(negedge clk);
        bus_we = 1'b0;
    endtask

    // Compare process picks up the expected value
    task automatic read_reg(input regmap_pkg::bus_addr_t addr, input string what);
        @(negedge clk);
        bus_addr = addr;
        exp_q.push_back(exp_read(addr));
        what_q.push_back(what);
        @(posedge clk);
    endtask

    task automatic wait_tx_enable(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (tx_enable !== level) begin
            if (n == max_cycles) begin
                fail_run($sformatf("tx_enable_o did not reach %0b within %0d cycles",
                                   level, max_cycles));
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    // Transmitter reports the message sent, FSM drops back to idle
    task automatic finish_message();
        @(negedge clk);
        tx_done = 1'b1;
        wait_tx_enable(1'b0, 8);
        tx_done = 1'b0;
    endtask

    task automatic test_reset_readback();
        @(negedge clk);
        check_outputs(3'b000, "outputs after reset");
        read_reg(regmap_pkg::REG_CTRL, "control register after reset");
        for (int ch = 0; ch < ctrl_pkg::NUM_CHANNELS; ch++) begin
            write_reg(table_addr(regmap_pkg::REGION_BASELINE, ch), $random(seed));
            write_reg(table_addr(regmap_pkg::REGION_NOISE, ch), $random(seed));
        end
        for (int ch = 0; ch < ctrl_pkg::NUM_CHANNELS; ch++) begin
            read_reg(table_addr(regmap_pkg::REGION_BASELINE, ch),
                     $sformatf("baseline channel %0d", ch));
            read_reg(table_addr(regmap_pkg::REGION_NOISE, ch), $sformatf("noise channel %0d", ch));
        end
        read_reg(table_addr(regmap_pkg::REGION_BASELINE, 4), "baseline channel 4");
        read_reg(16'h5008, "address outside the map");
    endtask

    task automatic test_status_report();
        ctrl_pkg::mode_t modes [4];
        modes = '{ctrl_pkg::MODE_IDLE, ctrl_pkg::MODE_CAL, ctrl_pkg::MODE_ACQ, 5'd7};
        for (int m = 0; m < 4; m++) begin
            write_reg(regmap_pkg::REG_MODE, regmap_pkg::bus_data_t'(modes[m]));
            if (m == 0) begin
                // First transmit enable after reset releases one packet
                @(negedge clk);
                check_outputs(3'b110, "first message after reset");
                @(negedge clk);
                check_outputs(3'b111, "first packet release");
                @(negedge clk);
                check_outputs(3'b110, "first release is one cycle");
            end
            for (int s = 0; s <= int'(ctrl_pkg::STAT_CLUSTER_FINDING); s++) begin
                write_reg(regmap_pkg::REG_STATUS, regmap_pkg::bus_data_t'(s));
                read_reg(regmap_pkg::REG_STATUS,
                         $sformatf("status in mode %0d after writing %0d", modes[m], s));
            end
        end
        write_reg(regmap_pkg::REG_MODE, regmap_pkg::bus_data_t'(ctrl_pkg::MODE_IDLE));
        write_reg(regmap_pkg::REG_STATUS, regmap_pkg::bus_data_t'(ctrl_pkg::STAT_WAIT));
        finish_message();
        repeat (4) @(negedge clk);    // Let the release pulse pass
    endtask

    task automatic test_mode_message();
        write_reg(regmap_pkg::REG_MODE, regmap_pkg::bus_data_t'(ctrl_pkg::MODE_CAL));
        check_outputs(3'b000, "one edge after mode write");
        @(negedge clk);
        check_outputs(3'b110, "two edges after mode write");
        repeat (5) begin
            @(negedge clk);
            check_outputs(3'b110, "message held without tx_done");
        end
        tx_done = 1'b1;
        @(negedge clk);
        tx_done = 1'b0;
        check_outputs(3'b110, "edge sampling tx_done");
        @(negedge clk);
        check_outputs(3'b000, "one edge after tx_done");
        @(negedge clk);
        check_outputs(3'b001, "two edges after tx_done");
        @(negedge clk);
        check_outputs(3'b000, "release pulse is one cycle");
    endtask

    task automatic test_acquisition();
        ctrl_pkg::adc_bus_t samples;
        write_reg(regmap_pkg::REG_STATUS, regmap_pkg::bus_data_t'(ctrl_pkg::STAT_INIT_FINISH));
        write_reg(regmap_pkg::REG_CTRL, 32'h0003_0000);    // Capture and transmit enabled
        write_reg(regmap_pkg::REG_MODE, regmap_pkg::bus_data_t'(ctrl_pkg::MODE_ACQ));
        wait_tx_enable(1'b1, 4);
        finish_message();
        tx_busy = 1'b1;
        samples = ctrl_pkg::adc_bus_t'({$random(seed), $random(seed)});
        @(negedge clk);
        check({31'd0, tx_enable}, 32'd0, "tx_enable_o before samples");
        adc_data  = samples;
        adc_valid = 1'b1;
        for (int ch = 0; ch < ctrl_pkg::NUM_CHANNELS; ch++) begin
            model_adc[ch] = {4'd0, samples[ch*ctrl_pkg::ADC_WIDTH +: ctrl_pkg::ADC_WIDTH]};
        end
        @(negedge clk);
        adc_valid = 1'b0;
        wait_tx_enable(1'b1, 8);
        for (int ch = 0; ch < ctrl_pkg::NUM_CHANNELS; ch++) begin
            read_reg(table_addr(regmap_pkg::REGION_ADC, ch), $sformatf("adc channel %0d", ch));
        end
        @(negedge clk);
        check({31'd0, tx_enable}, 32'd1, "tx_enable_o held by busy transmitter");
        tx_busy = 1'b0;
        wait_tx_enable(1'b0, 4);
    endtask

    task automatic test_cal_gating();
        write_reg(regmap_pkg::REG_MODE, regmap_pkg::bus_data_t'(ctrl_pkg::MODE_CAL));
        wait_tx_enable(1'b1, 4);
        finish_message();
        tx_busy = 1'b1;
        repeat (10) begin
            @(negedge clk);
            adc_valid = 1'b1;
            @(negedge clk);
            adc_valid = 1'b0;
            check({31'd0, tx_enable}, 32'd0, "tx_enable_o while calibrating");
        end
        write_reg(regmap_pkg::REG_STATUS,
                  regmap_pkg::bus_data_t'(ctrl_pkg::STAT_MEASURE_FINISH));
        wait_tx_enable(1'b1, 4);
        read_reg(regmap_pkg::REG_STATUS, "status after measurement finished");
        repeat (8) begin
            @(negedge clk);
            check({31'd0, data_accept}, 32'd1, "data_accept_o with measurement finished");
        end
    endtask

    // Read compare, a quarter period after the address settles
    initial begin
        forever begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
            if (exp_q.size() > 0) begin
                check(bus_rdata, exp_q.pop_front(), what_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        seed       = 29;
        rst_n      = 1'b0;
        bus_addr   = '0;
        bus_wdata  = '0;
        bus_we     = 1'b0;
        adc_data   = '0;
        adc_valid  = 1'b0;
        tx_busy    = 1'b0;
        tx_done    = 1'b0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_readback();
        test_status_report();
        test_mode_message();
        test_acquisition();
        test_cal_gating();

        repeat (2) @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+dv
rtl/regmap_pkg.sv
rtl/ctrl_pkg.sv
rtl/reg_bank.sv
rtl/acq_fsm.sv
rtl/tx_release.sv
rtl/acq_ctrl_top.sv
dv/tb_acq_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_acq_ctrl
FLIST     ?= sources.f
BUILD_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Exit status of the simulation binary is the test result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
